// ==== verilog.f ====
+incdir+tests
source/ram_pkg.sv
source/ram_write_channel.sv
source/ram_read_channel.sv
source/ram_core.sv
source/ram_pause.sv
source/ram_subsystem.sv
tests/ram_tb.sv

// ==== tests/ram_tb_model.svh ====
`ifndef RAM_TB_MODEL_SVH
`define RAM_TB_MODEL_SVH

// Random source and reference memory keyed by word index
logic [31:0]           lfsr_state = 32'h16547e92;
logic [data_width-1:0] ref_mem [int];

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// One LFSR step for every bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [data_width-1:0] merge_strobes(input logic [data_width-1:0] old,
                                                      input logic [data_width-1:0] data,
                                                      input logic [strb_width-1:0] strb);
    logic [data_width-1:0] v;
    v = old;
    for (int i = 0; i < strb_width; i++) begin
        if (strb[i]) begin
            v[i*8 +: 8] = data[i*8 +: 8];
        end
    end
    return v;
endfunction

// Word-aligned address decides the response
function automatic axil_resp_e expect_resp(input logic [addr_width-1:0] addr);
    return (int'({addr[addr_width-1:2], 2'b00}) < mem_bytes) ? resp_okay : resp_decerr;
endfunction

function automatic logic [data_width-1:0] expect_rdata(input logic [addr_width-1:0] addr);
    if (expect_resp(addr) != resp_okay) begin
        return '0;
    end
    return ref_mem[addr[addr_width-1:2]];
endfunction

function automatic void model_write(input logic [addr_width-1:0] addr,
                                    input logic [data_width-1:0] data,
                                    input logic [strb_width-1:0] strb);
    logic [data_width-1:0] old;
    if (expect_resp(addr) != resp_okay) begin
        return;
    end
    old = ref_mem.exists(addr[addr_width-1:2]) ? ref_mem[addr[addr_width-1:2]] : '0;
    ref_mem[addr[addr_width-1:2]] = merge_strobes(old, data, strb);
endfunction

`endif

// ==== tests/ram_tb.sv ====
`default_nettype none

module ram_tb;
    import ram_pkg::*;

    localparam int mem_bytes  = 4096;
    localparam int txn_count  = 16*2 + 16*2 + 8*3 + 24*2 + 8*2;
    localparam int txn_cycles = 40;

    logic     seq;
    logic     arst_n;
    axil_aw_t aw;
    logic     aw_valid, aw_ready;
    axil_w_t  w;
    logic     w_valid, w_ready;
    axil_ar_t ar;
    logic     ar_valid, ar_ready;
    axil_b_t  b;
    logic     b_valid, b_ready;
    axil_r_t  r;
    logic     r_valid, r_ready;
    logic     pause_req, pause_ack;

    `include "ram_tb_model.svh"

    // Expected responses in issue order
    axil_resp_e  exp_b [$];
    axil_r_t     exp_r [$];
    logic [15:0] written [$];
    logic [15:0] wr_addr [24];
    logic [31:0] wr_data [24];
    logic [3:0]  wr_strb [24];
    logic [15:0] rd_addr [24];
    logic        streams_done = 1'b0;
    int          errors = 0, checks = 0, test_num = 0, tests_failed = 0;
    int          aw_hs = 0, w_hs = 0, ar_hs = 0, b_hs = 0, r_hs = 0;

    ram_subsystem #(.mem_bytes(mem_bytes)) uut (
        .seq(seq), .arst_n(arst_n),
        .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
        .w(w), .w_valid(w_valid), .w_ready(w_ready),
        .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .r(r), .r_valid(r_valid), .r_ready(r_ready),
        .pause_req(pause_req), .pause_ack(pause_ack)
    );

    always #5 seq = ~seq;

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, expv, actv);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("%0t %s", $time, what);
        errors++;
    endtask

    // Response and pause checks on every rising edge
    always @(posedge seq) begin : check_responses
        axil_resp_e eb;
        axil_r_t    er;
        if (aw_valid && aw_ready) aw_hs++;
        if (w_valid && w_ready) w_hs++;
        if (ar_valid && ar_ready) ar_hs++;
        if (b_valid && b_ready) begin
            b_hs++;
            checks++;
            assert (exp_b.size() != 0) else report_failure("write response with nothing outstanding");
            if (exp_b.size() != 0) begin
                eb = exp_b.pop_front();
                assert (b.resp == eb) else report_mismatch("b.resp", eb, b.resp);
            end
        end
        if (r_valid && r_ready) begin
            r_hs++;
            checks++;
            assert (exp_r.size() != 0) else report_failure("read response with nothing outstanding");
            if (exp_r.size() != 0) begin
                er = exp_r.pop_front();
                assert (r.resp == er.resp) else report_mismatch("r.resp", er.resp, r.resp);
                assert (r.data == er.data) else report_mismatch("r.data", er.data, r.data);
            end
        end
        if (pause_ack) begin
            checks++;
            assert (aw_hs == b_hs && w_hs == b_hs && ar_hs == r_hs)
                else report_failure("pause_ack high while responses are still outstanding");
            assert (!aw_ready && !w_ready && !ar_ready)
                else report_failure("aw, w or ar ready high while paused");
        end
    end

    // Starts and ends on a falling edge
    task automatic send_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic aw_done;
        logic w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        exp_b.push_back(expect_resp(addr));
        model_write(addr, data, strb);
        aw.addr  = addr;
        w.data   = data;
        w.strb   = strb;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge seq);
            if (aw_valid && aw_ready) aw_done = 1'b1;
            if (w_valid && w_ready) w_done = 1'b1;
            @(negedge seq);
            if (aw_done) aw_valid = 1'b0;
            if (w_done) w_valid = 1'b0;
        end
    endtask

    task automatic send_read(input logic [15:0] addr);
        axil_r_t er;
        logic    done;
        er.data  = expect_rdata(addr);
        er.resp  = expect_resp(addr);
        exp_r.push_back(er);
        ar.addr  = addr;
        ar_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(posedge seq);
            done = ar_valid && ar_ready;
            @(negedge seq);
        end
        ar_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_b.size() != 0 || exp_r.size() != 0) @(negedge seq);
    endtask

    // Writes go above word 511, reads hit words written in the first test
    task automatic fill_traffic(input int n);
        logic [15:0] word;
        for (int i = 0; i < n; i++) begin
            word       = 16'd512 + 16'(rand_bits(9));
            wr_addr[i] = {word[13:0], 2'b00};
            wr_data[i] = rand_bits(32);
            wr_strb[i] = 4'(rand_bits(4));
            word       = written[rand_bits(4)];
            rd_addr[i] = {word[13:0], 2'(rand_bits(2))};
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_num++;
        if (errors == errors_before) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", test_num, name, errors - errors_before);
        end
    endtask

    initial begin
        logic [15:0] word;
        logic [15:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  lo;
        int          e0;
        seq = 1'b0;
        arst_n = 1'b0;
        aw = '0;
        aw_valid = 1'b0;
        w = '0;
        w_valid = 1'b0;
        ar = '0;
        ar_valid = 1'b0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        pause_req = 1'b0;
        repeat (4) @(posedge seq);
        @(negedge seq);
        arst_n = 1'b1;
        @(negedge seq);

        e0 = errors;
        repeat (16) begin
            word = 16'(rand_bits(9));
            data = rand_bits(32);
            written.push_back(word);
            send_write({word[13:0], 2'b00}, data, 4'hf);
            wait_idle();
            send_read({word[13:0], 2'b00});
            wait_idle();
        end
        end_test("full-strobe write and read", e0);

        e0 = errors;
        repeat (16) begin
            word = written[rand_bits(4)];
            lo   = 2'(rand_bits(2));
            data = rand_bits(32);
            strb = 4'(rand_bits(4));
            send_write({word[13:0], lo}, data, strb);
            wait_idle();
            lo = 2'(rand_bits(2));
            send_read({word[13:0], lo});
            wait_idle();
        end
        end_test("partial strobes and unaligned addresses", e0);

        // Out-of-range addresses alias a written word modulo the memory size
        e0 = errors;
        repeat (8) begin
            word = written[rand_bits(4)];
            addr = {word[13:0], 2'b00} + 16'(mem_bytes) * (16'(rand_bits(3)) + 16'd1);
            data = rand_bits(32);
            send_write(addr, data, 4'hf);
            wait_idle();
            send_read(addr);
            wait_idle();
            send_read({word[13:0], 2'b00});
            wait_idle();
        end
        end_test("out-of-range decode error", e0);

        e0 = errors;
        fill_traffic(24);
        streams_done = 1'b0;
        fork
            begin
                fork
                    for (int i = 0; i < 24; i++) send_write(wr_addr[i], wr_data[i], wr_strb[i]);
                    for (int i = 0; i < 24; i++) send_read(rd_addr[i]);
                join
                streams_done = 1'b1;
            end
            while (!streams_done || exp_b.size() != 0 || exp_r.size() != 0) begin
                @(negedge seq);
                b_ready = (rand_bits(2) != 0);
                r_ready = (rand_bits(2) != 0);
            end
        join
        b_ready = 1'b1;
        r_ready = 1'b1;
        end_test("concurrent traffic with response back-pressure", e0);

        e0 = errors;
        fill_traffic(8);
        fork
            for (int i = 0; i < 8; i++) send_write(wr_addr[i], wr_data[i], wr_strb[i]);
            for (int i = 0; i < 8; i++) send_read(rd_addr[i]);
            begin
                repeat (3) @(negedge seq);
                pause_req = 1'b1;
                // Stall b so the drain has something to wait for
                b_ready = 1'b0;
                repeat (4) @(negedge seq);
                b_ready = 1'b1;
                while (!pause_ack) @(negedge seq);
                repeat (5) begin
                    @(negedge seq);
                    checks++;
                    assert (pause_ack) else report_failure("pause_ack fell while pause_req was high");
                end
                pause_req = 1'b0;
                @(negedge seq);
                checks++;
                assert (!pause_ack) else report_failure("pause_ack still high after pause_req fell");
            end
        join
        wait_idle();
        end_test("pause during traffic", e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Bound derived from the number of transactions in all tests
    initial begin
        #(txn_count * txn_cycles * 10);
        $display("timeout, run did not finish within %0d cycles", txn_count * txn_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/ram_subsystem.sv ====
`default_nettype none

module ram_subsystem #(
    parameter int mem_bytes = 4096
) (
    input  logic              seq,
    input  logic              arst_n,

    input  ram_pkg::axil_aw_t aw,
    input  logic              aw_valid,
    output logic              aw_ready,

    input  ram_pkg::axil_w_t  w,
    input  logic              w_valid,
    output logic              w_ready,

    input  ram_pkg::axil_ar_t ar,
    input  logic              ar_valid,
    output logic              ar_ready,

    output ram_pkg::axil_b_t  b,
    output logic              b_valid,
    input  logic              b_ready,

    output ram_pkg::axil_r_t  r,
    output logic              r_valid,
    input  logic              r_ready,

    input  logic              pause_req,
    output logic              pause_ack
);
    import ram_pkg::*;

    wr_req_t wr_req;
    logic    wr_req_valid;
    logic    wr_req_ready;
    rd_req_t rd_req;
    logic    rd_req_valid;
    logic    rd_req_ready;

    logic    write_busy;
    logic    read_busy;
    logic    core_busy;
    logic    hold;

    // Write path joins aw and w before the core
    ram_write_channel u_write_channel (
        .seq          (seq),
        .arst_n       (arst_n),
        .hold         (hold),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .busy         (write_busy)
    );

    ram_read_channel u_read_channel (
        .seq          (seq),
        .arst_n       (arst_n),
        .hold         (hold),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .busy         (read_busy)
    );

    ram_core #(
        .mem_bytes (mem_bytes)
    ) u_core (
        .seq          (seq),
        .arst_n       (arst_n),
        .wr_req       (wr_req),
        .wr_req_valid (wr_req_valid),
        .wr_req_ready (wr_req_ready),
        .rd_req       (rd_req),
        .rd_req_valid (rd_req_valid),
        .rd_req_ready (rd_req_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .busy         (core_busy)
    );

    // Quiesce control for clock or power changes
    ram_pause u_pause (
        .seq        (seq),
        .arst_n     (arst_n),
        .pause_req  (pause_req),
        .pause_ack  (pause_ack),
        .write_busy (write_busy),
        .read_busy  (read_busy),
        .core_busy  (core_busy),
        .hold       (hold)
    );

endmodule

`default_nettype wire

// ==== source/ram_pause.sv ====
`default_nettype none

module ram_pause (
    input  logic seq,
    input  logic arst_n,

    input  logic pause_req,
    output logic pause_ack,

    input  logic write_busy,
    input  logic read_busy,
    input  logic core_busy,

    output logic hold
);
    import ram_pkg::*;

    pause_state_e state;
    pause_state_e state_next;
    logic         drained;

    // Nothing buffered in the channel slots or response registers
    assign drained = !write_busy && !read_busy && !core_busy;

    always_comb begin
        state_next = state;
        case (state)
            st_run: begin
                if (pause_req) begin
                    state_next = st_drain;
                end
            end
            st_drain: begin
                if (drained) begin
                    state_next = st_paused;
                end
            end
            st_paused: begin
                // Fourth phase releases on request withdrawal
                if (!pause_req) begin
                    state_next = st_run;
                end
            end
            default: begin
                state_next = st_run;
            end
        endcase
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_run;
        end else begin
            state <= state_next;
        end
    end

    // Both follow the registered state, so they drop together
    assign hold      = (state != st_run);
    assign pause_ack = (state == st_paused);

endmodule

`default_nettype wire

// ==== source/ram_core.sv ====
`default_nettype none

module ram_core #(
    parameter int mem_bytes = 4096
) (
    input  logic             seq,
    input  logic             arst_n,

    input  ram_pkg::wr_req_t wr_req,
    input  logic             wr_req_valid,
    output logic             wr_req_ready,

    input  ram_pkg::rd_req_t rd_req,
    input  logic             rd_req_valid,
    output logic             rd_req_ready,

    output ram_pkg::axil_b_t b,
    output logic             b_valid,
    input  logic             b_ready,

    output ram_pkg::axil_r_t r,
    output logic             r_valid,
    input  logic             r_ready,

    output logic             busy
);
    import ram_pkg::*;

    localparam int word_count  = mem_bytes / strb_width;
    localparam int lane_bits   = $clog2(strb_width);
    localparam int index_width = (word_count > 1) ? $clog2(word_count) : 1;

    // Word-wide storage with one entry per aligned address
    logic [data_width-1:0] mem [word_count];

    logic                            b_free;
    logic                            r_free;
    logic                            wr_accept;
    logic                            rd_accept;
    logic [addr_width-1:0]           req_addr;
    logic [addr_width-lane_bits-1:0] word_addr;
    logic [index_width-1:0]          word_idx;
    logic                            in_range;

    // A response slot is free when empty or being taken this cycle
    assign b_free = !b_valid || b_ready;
    assign r_free = !r_valid || r_ready;

    // Writes win and a read waits for a cycle with no accepted write
    assign wr_req_ready = b_free;
    assign wr_accept    = wr_req_valid && wr_req_ready;
    assign rd_req_ready = r_free && !wr_accept;
    assign rd_accept    = rd_req_valid && rd_req_ready;

    // Shared address path drops the byte offset within the word
    assign req_addr  = wr_accept ? wr_req.addr : rd_req.addr;
    assign word_addr = req_addr[addr_width-1:lane_bits];
    assign word_idx  = word_addr[index_width-1:0];
    assign in_range  = int'(word_addr) < word_count;

    assign busy = b_valid || r_valid;

    // Strobed byte-lane write
    always_ff @(posedge seq) begin
        if (wr_accept && in_range) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_req.strb[i]) begin
                    mem[word_idx][i*8 +: 8] <= wr_req.data[i*8 +: 8];
                end
            end
        end
    end

    // Response payloads are held until the matching handshake
    always_ff @(posedge seq) begin
        if (wr_accept) begin
            b.resp <= in_range ? resp_okay : resp_decerr;
        end
        if (rd_accept) begin
            r.resp <= in_range ? resp_okay : resp_decerr;
            // Decode errors read back as zero
            r.data <= in_range ? mem[word_idx] : '0;
        end
    end

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            b_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            if (wr_accept) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_accept) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_read_channel.sv ====
`default_nettype none

module ram_read_channel (
    input  logic              seq,
    input  logic              arst_n,
    input  logic              hold,

    input  ram_pkg::axil_ar_t ar,
    input  logic              ar_valid,
    output logic              ar_ready,

    output ram_pkg::rd_req_t  rd_req,
    output logic              rd_req_valid,
    input  logic              rd_req_ready,

    output logic              busy
);
    import ram_pkg::*;

    axil_ar_t ar_q;
    logic     ar_full;

    // ar_ready only looks at the local slot, never at core arbitration
    assign ar_ready = !ar_full && !hold;

    assign rd_req_valid = ar_full;
    assign rd_req.addr  = ar_q.addr;

    assign busy = ar_full;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            ar_full <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            ar_full <= 1'b1;
        end else if (rd_req_valid && rd_req_ready) begin
            ar_full <= 1'b0;
        end
    end

    // Address payload
    always_ff @(posedge seq) begin
        if (ar_valid && ar_ready) begin
            ar_q <= ar;
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_write_channel.sv ====
`default_nettype none

module ram_write_channel (
    input  logic              seq,
    input  logic              arst_n,
    input  logic              hold,

    input  ram_pkg::axil_aw_t aw,
    input  logic              aw_valid,
    output logic              aw_ready,

    input  ram_pkg::axil_w_t  w,
    input  logic              w_valid,
    output logic              w_ready,

    output ram_pkg::wr_req_t  wr_req,
    output logic              wr_req_valid,
    input  logic              wr_req_ready,

    output logic              busy
);
    import ram_pkg::*;

    axil_aw_t aw_q;
    axil_w_t  w_q;
    logic     aw_full;
    logic     w_full;
    logic     req_done;

    // Each slot takes a new entry only while empty and not paused
    assign aw_ready = !aw_full && !hold;
    assign w_ready  = !w_full && !hold;

    // Joined request once both halves have arrived
    assign wr_req_valid = aw_full && w_full;
    assign req_done     = wr_req_valid && wr_req_ready;

    assign wr_req.addr = aw_q.addr;
    assign wr_req.data = w_q.data;
    assign wr_req.strb = w_q.strb;

    assign busy = aw_full || w_full;

    always_ff @(posedge seq or negedge arst_n) begin
        if (!arst_n) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
        end else begin
            // A full slot cannot accept, so fill and drain never coincide
            if (aw_valid && aw_ready) begin
                aw_full <= 1'b1;
            end else if (req_done) begin
                aw_full <= 1'b0;
            end
            if (w_valid && w_ready) begin
                w_full <= 1'b1;
            end else if (req_done) begin
                w_full <= 1'b0;
            end
        end
    end

    // Slot payloads
    always_ff @(posedge seq) begin
        if (aw_valid && aw_ready) begin
            aw_q <= aw;
        end
        if (w_valid && w_ready) begin
            w_q <= w;
        end
    end

endmodule

`default_nettype wire

// ==== source/ram_pkg.sv ====
`default_nettype none

package ram_pkg;

    // Bus geometry
    localparam int addr_width = 16;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // The two AXI4-Lite response codes this slave can return
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_decerr = 2'b11
    } axil_resp_e;

    // Pause controller states
    typedef enum logic [1:0] {
        st_run,
        st_drain,
        st_paused
    } pause_state_e;

    // Bus channel payloads
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        axil_resp_e            resp;
    } axil_r_t;

    // Requests from the channel units to the core
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
    } wr_req_t;

    typedef struct packed {
        logic [addr_width-1:0] addr;
    } rd_req_t;

endpackage

`default_nettype wire
